// File: src/lm_pkg.sv
package lm_pkg;

  // --------------------------------------------------
  // sequence and datapath sizes
  localparam int N        = 4;
  localparam int CHAR_LEN = 8;
  localparam int EMB_DIM  = 2;
  localparam int VAL_LEN  = 8;
  localparam int CHAR_NUM = 4;
  localparam int ACC_LEN  = 16;
  localparam int POS_LEN  = $clog2(N);
  localparam int CLS_LEN  = $clog2(CHAR_NUM);

  localparam logic [CHAR_LEN-1:0] PAD_CHAR  = 8'h20;
  localparam logic [CHAR_LEN-1:0] CHAR_BASE = 8'h61;

  // one row per class, one column per embedding value
  localparam int DENSE_W [CHAR_NUM][EMB_DIM] = '{'{1, 0}, '{0, 1}, '{1, -1}, '{-1, 1}};

  // --------------------------------------------------
  // register map
  localparam int AXIL_ADDR_LEN = 4;
  localparam int AXIL_DATA_LEN = 32;

  localparam logic [AXIL_ADDR_LEN-1:0] ADDR_CTRL   = 4'h0;
  localparam logic [AXIL_ADDR_LEN-1:0] ADDR_STATUS = 4'h4;
  localparam logic [AXIL_ADDR_LEN-1:0] ADDR_LED    = 4'h8;

  typedef enum logic [3:0] {
    ST_IDLE, ST_RECV, ST_EMB, ST_MIX1, ST_MIX2, ST_DENS, ST_COMP, ST_SEND, ST_FIN
  } state_e;

  // --------------------------------------------------
  // payload types
  typedef struct packed {
    logic [CHAR_LEN-1:0] data;
    logic                last;
  } char_beat_t;

  typedef logic [N-1:0][CHAR_LEN-1:0] char_seq_t;

  typedef logic signed [VAL_LEN-1:0] val_t;
  typedef logic signed [ACC_LEN-1:0] acc_t;

  typedef val_t [N-1:0][EMB_DIM-1:0]  emb_vec_t;
  typedef acc_t [N-1:0][CHAR_NUM-1:0] score_vec_t;

  typedef struct packed {
    logic [AXIL_ADDR_LEN-1:0] addr;
    logic [2:0]               prot;
  } axil_aw_t;

  typedef struct packed {
    logic [AXIL_DATA_LEN-1:0]   data;
    logic [AXIL_DATA_LEN/8-1:0] strb;
  } axil_w_t;

  typedef struct packed {
    logic [AXIL_ADDR_LEN-1:0] addr;
    logic [2:0]               prot;
  } axil_ar_t;

  typedef struct packed {
    logic [AXIL_DATA_LEN-1:0] data;
    logic [1:0]               resp;
  } axil_r_t;

endpackage

// File: src/axil_regs.sv
module axil_regs (
  input  logic              aclk,
  input  logic              rst,
  input  lm_pkg::axil_aw_t  s_axil_aw,
  input  logic              s_axil_awvalid,
  output logic              s_axil_awready,
  input  lm_pkg::axil_w_t   s_axil_w,
  input  logic              s_axil_wvalid,
  output logic              s_axil_wready,
  output logic              s_axil_bvalid,
  output logic [1:0]        s_axil_bresp,
  input  logic              s_axil_bready,
  input  lm_pkg::axil_ar_t  s_axil_ar,
  input  logic              s_axil_arvalid,
  output logic              s_axil_arready,
  output lm_pkg::axil_r_t   s_axil_r,
  output logic              s_axil_rvalid,
  input  logic              s_axil_rready,
  input  logic              busy,
  input  logic              done,
  output logic              start,
  output logic [3:0]        led_out
);

  logic                             wr_ready;
  logic                             wr_fire;
  logic                             rd_fire;
  logic [lm_pkg::AXIL_DATA_LEN-1:0] rd_data;

  // address and data are taken in the same cycle
  assign s_axil_awready = wr_ready;
  assign s_axil_wready  = wr_ready;
  assign s_axil_bresp   = 2'b00;

  assign wr_fire = wr_ready && s_axil_awvalid && s_axil_wvalid;
  assign rd_fire = s_axil_arready && s_axil_arvalid;

  // --------------------------------------------------
  // write channel
  always_ff @(posedge aclk) begin
    if (rst) begin
      wr_ready      <= 1'b0;
      s_axil_bvalid <= 1'b0;
      start         <= 1'b0;
      led_out       <= '0;
    end else begin
      wr_ready <= s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid && !wr_ready;
      start    <= wr_fire && (s_axil_aw.addr == lm_pkg::ADDR_CTRL)
                  && s_axil_w.strb[0] && s_axil_w.data[0];
      if (wr_fire) begin
        s_axil_bvalid <= 1'b1;
      end else if (s_axil_bready) begin
        s_axil_bvalid <= 1'b0;
      end
      if (wr_fire && (s_axil_aw.addr == lm_pkg::ADDR_LED) && s_axil_w.strb[0]) begin
        led_out <= s_axil_w.data[3:0];
      end
    end
  end

  // --------------------------------------------------
  // read channel
  always_comb begin
    rd_data = '0;
    case (s_axil_ar.addr)
      lm_pkg::ADDR_STATUS: rd_data[1:0] = {done, busy};
      lm_pkg::ADDR_LED:    rd_data[3:0] = led_out;
      default:             rd_data = '0;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      s_axil_arready <= 1'b0;
      s_axil_rvalid  <= 1'b0;
    end else begin
      s_axil_arready <= s_axil_arvalid && !s_axil_rvalid && !s_axil_arready;
      if (rd_fire) begin
        s_axil_rvalid <= 1'b1;
      end else if (s_axil_rready) begin
        s_axil_rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (rd_fire) begin
      s_axil_r.data <= rd_data;
      s_axil_r.resp <= 2'b00;
    end
  end

  // response must wait for the master
  a_bvalid_hold: assert property (@(posedge aclk) disable iff (rst)
    s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid);

endmodule

// File: src/seq_fsm.sv
module seq_fsm (
  input  logic          aclk,
  input  logic          rst,
  input  logic          start,
  input  logic          recv_valid,
  input  logic          emb_valid,
  input  logic          mix_valid,
  input  logic          dense_valid,
  input  logic          comp_valid,
  input  logic          send_valid,
  output lm_pkg::state_e state
);

  lm_pkg::state_e state_next;

  // only the owner of the current state may advance it
  always_comb begin
    state_next = state;
    case (state)
      lm_pkg::ST_IDLE: if (start)       state_next = lm_pkg::ST_RECV;
      lm_pkg::ST_RECV: if (recv_valid)  state_next = lm_pkg::ST_EMB;
      lm_pkg::ST_EMB:  if (emb_valid)   state_next = lm_pkg::ST_MIX1;
      lm_pkg::ST_MIX1: if (mix_valid)   state_next = lm_pkg::ST_MIX2;
      lm_pkg::ST_MIX2: if (mix_valid)   state_next = lm_pkg::ST_DENS;
      lm_pkg::ST_DENS: if (dense_valid) state_next = lm_pkg::ST_COMP;
      lm_pkg::ST_COMP: if (comp_valid)  state_next = lm_pkg::ST_SEND;
      lm_pkg::ST_SEND: if (send_valid)  state_next = lm_pkg::ST_FIN;
      lm_pkg::ST_FIN:  if (start)       state_next = lm_pkg::ST_RECV;
      default:                          state_next = lm_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      state <= lm_pkg::ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  a_state_legal: assert property (@(posedge aclk) disable iff (rst)
    state inside {lm_pkg::ST_IDLE, lm_pkg::ST_RECV, lm_pkg::ST_EMB, lm_pkg::ST_MIX1,
                  lm_pkg::ST_MIX2, lm_pkg::ST_DENS, lm_pkg::ST_COMP, lm_pkg::ST_SEND,
                  lm_pkg::ST_FIN});

endmodule

// File: src/char_stream_in.sv
module char_stream_in (
  input  logic               aclk,
  input  logic               rst,
  input  logic               run,
  input  lm_pkg::char_beat_t s_axis,
  input  logic               s_axis_tvalid,
  output logic               s_axis_tready,
  output logic               valid,
  output lm_pkg::char_seq_t  q
);

  logic [lm_pkg::POS_LEN-1:0] pos;
  logic                       ended;
  logic                       run_q;
  logic                       take;
  logic                       take_end;

  assign s_axis_tready = run && !ended;
  assign take          = s_axis_tready && s_axis_tvalid;
  assign take_end      = take && (s_axis.last || (pos == lm_pkg::POS_LEN'(lm_pkg::N - 1)));

  always_ff @(posedge aclk) begin
    if (rst) begin
      pos   <= '0;
      ended <= 1'b0;
      run_q <= 1'b0;
      valid <= 1'b0;
    end else begin
      run_q <= run;
      valid <= take_end;
      if (!run) begin
        pos   <= '0;
        ended <= 1'b0;
      end else if (take) begin
        pos   <= pos + 1'b1;
        ended <= take_end;
      end
    end
  end

  // pad on entry, a beat taken in the same cycle still lands
  always_ff @(posedge aclk) begin
    if (run && !run_q) begin
      q <= {lm_pkg::N{lm_pkg::PAD_CHAR}};
    end
    if (take) begin
      q[pos] <= s_axis.data;
    end
  end

endmodule

// File: src/emb_layer.sv
module emb_layer (
  input  logic              aclk,
  input  logic              rst,
  input  logic              run,
  input  lm_pkg::char_seq_t d,
  output logic              valid,
  output lm_pkg::emb_vec_t  q
);

  logic run_q;

  always_ff @(posedge aclk) begin
    if (rst) begin
      run_q <= 1'b0;
      valid <= 1'b0;
    end else begin
      run_q <= run;
      valid <= run && !run_q;
    end
  end

  // nibbles zero-extended, so always non-negative
  always_ff @(posedge aclk) begin
    if (run && !run_q) begin
      for (int i = 0; i < lm_pkg::N; i++) begin
        q[i][0] <= lm_pkg::val_t'(d[i][3:0]);
        q[i][1] <= lm_pkg::val_t'(d[i][7:4]);
      end
    end
  end

endmodule

// File: src/mix_layer.sv
module mix_layer (
  input  logic             aclk,
  input  logic             rst,
  input  logic             run,
  input  logic             first_pass,
  input  lm_pkg::emb_vec_t d_emb,
  output logic             valid,
  output lm_pkg::emb_vec_t q
);

  logic             run_q;
  logic             first_q;
  logic             pass_start;
  lm_pkg::emb_vec_t src;

  // run stays high across both passes, so a pass also starts when
  // first_pass falls
  assign pass_start = run && (!run_q || (first_pass != first_q));

  assign src = first_pass ? d_emb : q;

  always_ff @(posedge aclk) begin
    if (rst) begin
      run_q   <= 1'b0;
      first_q <= 1'b0;
      valid   <= 1'b0;
    end else begin
      run_q   <= run;
      first_q <= first_pass;
      valid   <= pass_start;
    end
  end

  // each position adds its right neighbor, wrapping at the end
  always_ff @(posedge aclk) begin
    if (pass_start) begin
      for (int i = 0; i < lm_pkg::N; i++) begin
        for (int k = 0; k < lm_pkg::EMB_DIM; k++) begin
          q[i][k] <= src[i][k] + src[(i + 1) % lm_pkg::N][k];
        end
      end
    end
  end

endmodule

// File: src/dense_layer.sv
module dense_layer (
  input  logic               aclk,
  input  logic               rst,
  input  logic               run,
  input  lm_pkg::emb_vec_t   d,
  output logic               valid,
  output lm_pkg::score_vec_t q
);

  logic [lm_pkg::POS_LEN-1:0] pos;
  logic                       fin;
  logic                       step;
  lm_pkg::acc_t               score [lm_pkg::CHAR_NUM];

  assign step = run && !fin;

  // --------------------------------------------------
  // position walker
  always_ff @(posedge aclk) begin
    if (rst) begin
      pos   <= '0;
      fin   <= 1'b0;
      valid <= 1'b0;
    end else begin
      valid <= step && (pos == lm_pkg::POS_LEN'(lm_pkg::N - 1));
      if (!run) begin
        pos <= '0;
        fin <= 1'b0;
      end else if (step) begin
        pos <= pos + 1'b1;
        fin <= (pos == lm_pkg::POS_LEN'(lm_pkg::N - 1));
      end
    end
  end

  // --------------------------------------------------
  // weighted sum for every class of the current position
  always_comb begin
    for (int c = 0; c < lm_pkg::CHAR_NUM; c++) begin
      score[c] = '0;
      for (int k = 0; k < lm_pkg::EMB_DIM; k++) begin
        score[c] = score[c] + lm_pkg::acc_t'(d[pos][k] * lm_pkg::DENSE_W[c][k]);
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (step) begin
      for (int c = 0; c < lm_pkg::CHAR_NUM; c++) begin
        q[pos][c] <= score[c];
      end
    end
  end

endmodule

// File: src/comp_layer.sv
module comp_layer (
  input  logic               aclk,
  input  logic               rst,
  input  logic               run,
  input  lm_pkg::score_vec_t d,
  output logic               valid,
  output lm_pkg::char_seq_t  q
);

  logic [lm_pkg::POS_LEN-1:0] pos;
  logic                       fin;
  logic                       step;
  logic [lm_pkg::CLS_LEN-1:0] best_idx;
  lm_pkg::acc_t               best;

  assign step = run && !fin;

  always_ff @(posedge aclk) begin
    if (rst) begin
      pos   <= '0;
      fin   <= 1'b0;
      valid <= 1'b0;
    end else begin
      valid <= step && (pos == lm_pkg::POS_LEN'(lm_pkg::N - 1));
      if (!run) begin
        pos <= '0;
        fin <= 1'b0;
      end else if (step) begin
        pos <= pos + 1'b1;
        fin <= (pos == lm_pkg::POS_LEN'(lm_pkg::N - 1));
      end
    end
  end

  // strict compare keeps the lowest index on ties
  always_comb begin
    best     = d[pos][0];
    best_idx = '0;
    for (int c = 1; c < lm_pkg::CHAR_NUM; c++) begin
      if (d[pos][c] > best) begin
        best     = d[pos][c];
        best_idx = lm_pkg::CLS_LEN'(c);
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (step) begin
      q[pos] <= lm_pkg::CHAR_BASE + lm_pkg::CHAR_LEN'(best_idx);
    end
  end

endmodule

// File: src/char_stream_out.sv
module char_stream_out (
  input  logic               aclk,
  input  logic               rst,
  input  logic               run,
  input  lm_pkg::char_seq_t  d,
  input  logic               m_axis_tready,
  output lm_pkg::char_beat_t m_axis,
  output logic               m_axis_tvalid,
  output logic               valid
);

  logic [lm_pkg::POS_LEN-1:0] pos;
  logic                       fin;
  logic                       xfer;

  assign m_axis_tvalid = run && !fin;
  assign m_axis.data   = d[pos];
  assign m_axis.last   = (pos == lm_pkg::POS_LEN'(lm_pkg::N - 1));
  assign xfer          = m_axis_tvalid && m_axis_tready;

  // pos only moves on a transfer, so data holds under back-pressure
  always_ff @(posedge aclk) begin
    if (rst) begin
      pos   <= '0;
      fin   <= 1'b0;
      valid <= 1'b0;
    end else begin
      valid <= xfer && m_axis.last;
      if (!run) begin
        pos <= '0;
        fin <= 1'b0;
      end else if (xfer) begin
        pos <= pos + 1'b1;
        fin <= m_axis.last;
      end
    end
  end

  a_beat_stable: assert property (@(posedge aclk) disable iff (rst)
    m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis));

endmodule

// File: src/lm_accel_top.sv
module lm_accel_top (
  input  logic               aclk,
  input  logic               rst,
  input  lm_pkg::axil_aw_t   s_axil_aw,
  input  logic               s_axil_awvalid,
  output logic               s_axil_awready,
  input  lm_pkg::axil_w_t    s_axil_w,
  input  logic               s_axil_wvalid,
  output logic               s_axil_wready,
  output logic               s_axil_bvalid,
  output logic [1:0]         s_axil_bresp,
  input  logic               s_axil_bready,
  input  lm_pkg::axil_ar_t   s_axil_ar,
  input  logic               s_axil_arvalid,
  output logic               s_axil_arready,
  output lm_pkg::axil_r_t    s_axil_r,
  output logic               s_axil_rvalid,
  input  logic               s_axil_rready,
  input  lm_pkg::char_beat_t s_axis,
  input  logic               s_axis_tvalid,
  output logic               s_axis_tready,
  output lm_pkg::char_beat_t m_axis,
  output logic               m_axis_tvalid,
  input  logic               m_axis_tready,
  output logic [3:0]         led_out
);

  // --------------------------------------------------
  // control and layer wires
  lm_pkg::state_e     state;
  logic               start;
  logic               busy;
  logic               done;
  logic               recv_valid;
  logic               emb_valid;
  logic               mix_valid;
  logic               dense_valid;
  logic               comp_valid;
  logic               send_valid;
  lm_pkg::char_seq_t  recv_q;
  lm_pkg::emb_vec_t   emb_q;
  lm_pkg::emb_vec_t   mix_q;
  lm_pkg::score_vec_t dense_q;
  lm_pkg::char_seq_t  comp_q;

  assign busy = (state != lm_pkg::ST_IDLE) && (state != lm_pkg::ST_FIN);
  assign done = (state == lm_pkg::ST_FIN);

  // --------------------------------------------------
  // control
  axil_regs u_regs (
    .aclk(aclk), .rst(rst),
    .s_axil_aw(s_axil_aw), .s_axil_awvalid(s_axil_awvalid), .s_axil_awready(s_axil_awready),
    .s_axil_w(s_axil_w), .s_axil_wvalid(s_axil_wvalid), .s_axil_wready(s_axil_wready),
    .s_axil_bvalid(s_axil_bvalid), .s_axil_bresp(s_axil_bresp), .s_axil_bready(s_axil_bready),
    .s_axil_ar(s_axil_ar), .s_axil_arvalid(s_axil_arvalid), .s_axil_arready(s_axil_arready),
    .s_axil_r(s_axil_r), .s_axil_rvalid(s_axil_rvalid), .s_axil_rready(s_axil_rready),
    .busy(busy), .done(done), .start(start), .led_out(led_out)
  );

  seq_fsm u_fsm (
    .aclk(aclk), .rst(rst), .start(start),
    .recv_valid(recv_valid), .emb_valid(emb_valid), .mix_valid(mix_valid),
    .dense_valid(dense_valid), .comp_valid(comp_valid), .send_valid(send_valid),
    .state(state)
  );

  // --------------------------------------------------
  // datapath, each run decoded straight from the state
  char_stream_in u_in (
    .aclk(aclk), .rst(rst), .run(state == lm_pkg::ST_RECV),
    .s_axis(s_axis), .s_axis_tvalid(s_axis_tvalid), .s_axis_tready(s_axis_tready),
    .valid(recv_valid), .q(recv_q)
  );

  emb_layer u_emb (
    .aclk(aclk), .rst(rst), .run(state == lm_pkg::ST_EMB),
    .d(recv_q), .valid(emb_valid), .q(emb_q)
  );

  // one instance serves both mixing passes
  mix_layer u_mix (
    .aclk(aclk), .rst(rst),
    .run((state == lm_pkg::ST_MIX1) || (state == lm_pkg::ST_MIX2)),
    .first_pass(state == lm_pkg::ST_MIX1),
    .d_emb(emb_q), .valid(mix_valid), .q(mix_q)
  );

  dense_layer u_dense (
    .aclk(aclk), .rst(rst), .run(state == lm_pkg::ST_DENS),
    .d(mix_q), .valid(dense_valid), .q(dense_q)
  );

  comp_layer u_comp (
    .aclk(aclk), .rst(rst), .run(state == lm_pkg::ST_COMP),
    .d(dense_q), .valid(comp_valid), .q(comp_q)
  );

  char_stream_out u_out (
    .aclk(aclk), .rst(rst), .run(state == lm_pkg::ST_SEND),
    .d(comp_q), .m_axis_tready(m_axis_tready),
    .m_axis(m_axis), .m_axis_tvalid(m_axis_tvalid), .valid(send_valid)
  );

endmodule

// File: sim/tb_lm_accel.sv
module tb_lm_accel;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_TESTS  = 5;
  localparam int TIMEOUT    = NUM_TESTS * 200 * CLK_PERIOD;

  logic               aclk;
  logic               rst;
  lm_pkg::axil_aw_t   s_axil_aw;
  logic               s_axil_awvalid;
  logic               s_axil_awready;
  lm_pkg::axil_w_t    s_axil_w;
  logic               s_axil_wvalid;
  logic               s_axil_wready;
  logic               s_axil_bvalid;
  logic [1:0]         s_axil_bresp;
  logic               s_axil_bready;
  lm_pkg::axil_ar_t   s_axil_ar;
  logic               s_axil_arvalid;
  logic               s_axil_arready;
  lm_pkg::axil_r_t    s_axil_r;
  logic               s_axil_rvalid;
  logic               s_axil_rready;
  lm_pkg::char_beat_t s_axis;
  logic               s_axis_tvalid;
  logic               s_axis_tready;
  lm_pkg::char_beat_t m_axis;
  logic               m_axis_tvalid;
  logic               m_axis_tready;
  logic [3:0]         led_out;

  int          errors;
  int          checks;
  int          test_errs;
  int          tests_run;
  logic [15:0] lfsr;

  lm_accel_top dut (.*);

  initial begin
    aclk = 1'b0;
    forever #(CLK_PERIOD / 2) aclk = ~aclk;
  end

  initial begin
    #(TIMEOUT);
    $display("watchdog expired at %0t, the DUT stopped responding", $time);
    $display("Checks failed");
    $finish;
  end

  // --------------------------------------------------
  // galois lfsr stepped once per bit
  function automatic logic next_rand_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) begin
      lfsr = lfsr ^ 16'hB400;
    end
    return out;
  endfunction

  function automatic logic [lm_pkg::CHAR_LEN-1:0] rand_char();
    logic [lm_pkg::CHAR_LEN-1:0] c;
    c = '0;
    for (int b = 0; b < lm_pkg::CHAR_LEN; b++) begin
      c = {c[lm_pkg::CHAR_LEN-2:0], next_rand_bit()};
    end
    return c;
  endfunction

  // --------------------------------------------------
  // reference model of embedding, two wrap-around mixes, scores and argmax
  function automatic lm_pkg::char_seq_t expected_out(input lm_pkg::char_seq_t seq);
    int                v [lm_pkg::N][lm_pkg::EMB_DIM];
    int                m [lm_pkg::N][lm_pkg::EMB_DIM];
    int                s [lm_pkg::CHAR_NUM];
    int                best;
    lm_pkg::char_seq_t res;
    for (int i = 0; i < lm_pkg::N; i++) begin
      v[i][0] = int'(seq[i][3:0]);
      v[i][1] = int'(seq[i][7:4]);
    end
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < lm_pkg::N; i++) begin
        for (int k = 0; k < lm_pkg::EMB_DIM; k++) begin
          m[i][k] = v[i][k] + v[(i + 1) % lm_pkg::N][k];
        end
      end
      v = m;
    end
    for (int i = 0; i < lm_pkg::N; i++) begin
      s[0] = v[i][0];
      s[1] = v[i][1];
      s[2] = v[i][0] - v[i][1];
      s[3] = v[i][1] - v[i][0];
      best = 0;
      for (int c = 1; c < lm_pkg::CHAR_NUM; c++) begin
        if (s[c] > s[best]) begin
          best = c;
        end
      end
      res[i] = 8'h61 + 8'(best);
    end
    return res;
  endfunction

  // --------------------------------------------------
  // compare tasks
  task automatic count_error();
    errors++;
    test_errs++;
  endtask

  task automatic report_failure(input string what);
    checks++;
    $display("%0t: %s", $time, what);
    count_error();
  endtask

  task automatic check_word(input string name, input logic [lm_pkg::AXIL_DATA_LEN-1:0] got,
                            input logic [lm_pkg::AXIL_DATA_LEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
      count_error();
    end
  endtask

  task automatic check_char(input string name, input lm_pkg::char_beat_t got,
                            input logic [lm_pkg::CHAR_LEN-1:0] exp);
    checks++;
    if (got.data !== exp) begin
      $display("** Error at %0t: %s = 0x%02h, expected 0x%02h", $time, name, got.data, exp);
      count_error();
    end
  endtask

  task automatic check_last(input string name, input lm_pkg::char_beat_t got, input logic exp);
    checks++;
    if (got.last !== exp) begin
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got.last, exp);
      count_error();
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (test_errs == 0) begin
      $display("test %-16s ok", name);
    end else begin
      $display("test %-16s %0d error(s)", name, test_errs);
    end
    test_errs = 0;
  endtask

  // --------------------------------------------------
  // bus drivers change inputs on the falling edge
  task automatic axil_write(input logic [lm_pkg::AXIL_ADDR_LEN-1:0] addr,
                            input logic [lm_pkg::AXIL_DATA_LEN-1:0] data);
    @(negedge aclk);
    s_axil_aw.addr = addr;
    s_axil_aw.prot = 3'b000;
    s_axil_w.data  = data;
    s_axil_w.strb  = '1;
    s_axil_awvalid = 1'b1;
    s_axil_wvalid  = 1'b1;
    @(negedge aclk);
    while (!s_axil_awready) @(negedge aclk);
    // address and data ready rise together
    check_word("s_axil_wready", 32'(s_axil_wready), 32'h1);
    @(negedge aclk);
    s_axil_awvalid = 1'b0;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = 1'b1;
    while (!s_axil_bvalid) @(negedge aclk);
    check_word("s_axil_bresp", 32'(s_axil_bresp), 32'h0);
    @(negedge aclk);
    s_axil_bready = 1'b0;
  endtask

  task automatic axil_read(input logic [lm_pkg::AXIL_ADDR_LEN-1:0] addr,
                           output lm_pkg::axil_r_t r);
    @(negedge aclk);
    s_axil_ar.addr = addr;
    s_axil_ar.prot = 3'b000;
    s_axil_arvalid = 1'b1;
    @(negedge aclk);
    while (!s_axil_arready) @(negedge aclk);
    @(negedge aclk);
    s_axil_arvalid = 1'b0;
    while (!s_axil_rvalid) @(negedge aclk);
    r = s_axil_r;
    s_axil_rready = 1'b1;
    @(negedge aclk);
    s_axil_rready = 1'b0;
  endtask

  task automatic read_and_check(input logic [lm_pkg::AXIL_ADDR_LEN-1:0] addr,
                                input logic [lm_pkg::AXIL_DATA_LEN-1:0] exp, input string name);
    lm_pkg::axil_r_t r;
    axil_read(addr, r);
    check_word(name, r.data, exp);
    check_word({name, " resp"}, 32'(r.resp), 32'h0);
  endtask

  task automatic send_seq(input lm_pkg::char_seq_t seq, input int count);
    @(negedge aclk);
    for (int i = 0; i < count; i++) begin
      s_axis.data   = seq[i];
      s_axis.last   = (i == count - 1);
      s_axis_tvalid = 1'b1;
      while (!s_axis_tready) @(negedge aclk);
      @(negedge aclk);
    end
    s_axis_tvalid = 1'b0;
    s_axis.last   = 1'b0;
  endtask

  // a beat counts when valid and ready are both high at the falling edge
  task automatic recv_seq(input lm_pkg::char_seq_t exp, input bit random_ready);
    lm_pkg::char_beat_t beat;
    int                 got_n;
    got_n = 0;
    while (got_n < lm_pkg::N) begin
      @(negedge aclk);
      if (random_ready) begin
        m_axis_tready = next_rand_bit();
      end else begin
        m_axis_tready = 1'b1;
      end
      if (m_axis_tvalid && m_axis_tready) begin
        beat = m_axis;
        check_char($sformatf("m_axis.data[%0d]", got_n), beat, exp[got_n]);
        check_last($sformatf("m_axis.last[%0d]", got_n), beat, got_n == lm_pkg::N - 1);
        got_n++;
      end
    end
    @(negedge aclk);
    m_axis_tready = 1'b0;
    if (m_axis_tvalid) begin
      report_failure("output stream kept tvalid high after the last beat");
    end
  endtask

  task automatic run_and_check(input lm_pkg::char_seq_t seq, input int count,
                               input bit random_ready, input bit watch_status);
    lm_pkg::char_seq_t padded;
    padded = seq;
    for (int i = count; i < lm_pkg::N; i++) begin
      padded[i] = 8'h20;
    end
    axil_write(lm_pkg::ADDR_CTRL, 32'h1);
    if (watch_status) begin
      read_and_check(lm_pkg::ADDR_STATUS, 32'h1, "status busy");
    end
    send_seq(seq, count);
    recv_seq(expected_out(padded), random_ready);
    if (watch_status) begin
      read_and_check(lm_pkg::ADDR_STATUS, 32'h2, "status done");
    end
  endtask

  // --------------------------------------------------
  // directed tests
  task automatic test_registers();
    read_and_check(lm_pkg::ADDR_STATUS, 32'h0, "status idle");
    axil_write(lm_pkg::ADDR_LED, 32'h5);
    check_word("led_out", 32'(led_out), 32'h5);
    read_and_check(lm_pkg::ADDR_LED, 32'h5, "led readback");
    read_and_check(4'hC, 32'h0, "unmapped read");
    report_test("registers");
  endtask

  task automatic test_full_seq();
    // position 0 on the right
    run_and_check({8'h7a, 8'h31, 8'h6d, 8'h4c}, 4, 1'b0, 1'b0);
    report_test("full_seq");
  endtask

  task automatic test_short_seq();
    // upper two positions are never sent
    run_and_check({8'hff, 8'hee, 8'h92, 8'h3f}, 2, 1'b0, 1'b0);
    report_test("short_seq");
  endtask

  task automatic test_backpressure();
    run_and_check({8'h0f, 8'hf0, 8'h55, 8'hc3}, 4, 1'b1, 1'b0);
    report_test("backpressure");
  endtask

  task automatic test_status_repeat();
    lm_pkg::char_seq_t seq;
    for (int r = 0; r < 2; r++) begin
      for (int i = 0; i < lm_pkg::N; i++) begin
        seq[i] = rand_char();
      end
      run_and_check(seq, 4, r == 1, 1'b1);
    end
    report_test("status_repeat");
  endtask

  initial begin
    rst            = 1'b1;
    s_axil_aw      = '0;
    s_axil_awvalid = 1'b0;
    s_axil_w       = '0;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = 1'b0;
    s_axil_ar      = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready  = 1'b0;
    s_axis         = '0;
    s_axis_tvalid  = 1'b0;
    m_axis_tready  = 1'b0;
    lfsr           = 16'd59;
    errors         = 0;
    checks         = 0;
    test_errs      = 0;
    tests_run      = 0;
    repeat (4) @(negedge aclk);
    rst = 1'b0;

    test_registers();
    test_full_seq();
    test_short_seq();
    test_backpressure();
    test_status_repeat();

    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: compile.f
src/lm_pkg.sv
src/axil_regs.sv
src/seq_fsm.sv
src/char_stream_in.sv
src/emb_layer.sv
src/mix_layer.sv
src/dense_layer.sv
src/comp_layer.sv
src/char_stream_out.sv
src/lm_accel_top.sv
sim/tb_lm_accel.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with verilator, run, then search the log for the fail message
set -o pipefail
verilator --binary --timing --assert -Wno-fatal --top-module tb_lm_accel -f compile.f \
  -o sim_lm_accel > build.log 2>&1 \
  && ./obj_dir/sim_lm_accel 2>&1 | tee sim.log \
  && ! grep -q "Checks failed" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }
